/* clic.f */
+incdir+dv
design/clic_params_pkg.sv
design/clic_map_pkg.sv
design/clic_irq_if.sv
design/clic_regs.sv
design/clic_gateway.sv
design/clic_arbiter.sv
design/clic_top.sv
dv/clic_tb.sv

/* Bender.yml */
package:
  name: clic

sources:
  - files:
      - design/clic_params_pkg.sv
      - design/clic_map_pkg.sv
      - design/clic_irq_if.sv
      - design/clic_regs.sv
      - design/clic_gateway.sv
      - design/clic_arbiter.sv
      - design/clic_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/clic_tb.sv

/* dv/clic_bus_tasks.svh */
// ==============================
// bus access
// ==============================

function automatic logic addr_mapped(input logic [31:0] addr);
  return (addr[31:2] == cfg_addr[31:2]) || (addr[31:2] == info_addr[31:2]) ||
         ((addr >= int_base) && (addr < int_end));
endfunction

function automatic logic [31:0] int_addr(input int id);
  return int_base + 32'(4 * id);
endfunction

// called 2 ns after an edge, returns 2 ns after the next one
task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
  bus_valid = 1'b1;
  bus_addr  = addr;
  bus_wdata = data;
  bus_wstrb = strb;
  @(posedge clock);
  #2;
  bus_valid = 1'b0;
  bus_addr  = '0;
  bus_wdata = '0;
  bus_wstrb = '0;
endtask

task automatic bus_read(input logic [31:0] addr);
  bus_write(addr, 32'h0, 4'h0);  // zero strobe is a read
endtask

task automatic idle(input int cycles);
  repeat (cycles) begin
    @(posedge clock);
    #2;
  end
endtask

task automatic clear_all();
  irq_lines = '0;
  idle(2);
  bus_write(cfg_addr, 32'h0, 4'h1);
  for (int id = 0; id < num_irq; id++) begin
    bus_write(int_addr(id), 32'h0, 4'hf);
  end
  idle(3);
endtask

task automatic finish_test(input string name, input int errs_at_start);
  tests_run++;
  if (errors == errs_at_start) begin
    $display("test %s: pass", name);
  end else begin
    tests_bad++;
    $display("test %s: FAIL with %0d check errors", name, errors - errs_at_start);
  end
endtask

// ==============================
// expected values
// ==============================

function automatic logic [7:0] level_of(input logic [7:0] ctl, input logic [3:0] nlbits);
  int         n;
  logic [7:0] v;
  n = nlbits;
  v = ctl;
  for (int b = 0; b < 8; b++) begin
    if (b < 8 - n) v[b] = 1'b1;  // bits below the level field
  end
  return v;
endfunction

function automatic logic [7:0] prio_of(input logic [7:0] ctl, input logic [3:0] nlbits);
  int         n;
  logic [7:0] v;
  n = nlbits;
  v = ctl;
  for (int b = 0; b < 8; b++) begin
    if (b >= 8 - n) v[b] = 1'b1;
  end
  return v;
endfunction

// key orders by level, then priority, then lower id
function automatic logic [12:0] model_winner();
  logic [21:0] key;
  logic [21:0] best;
  logic [12:0] res;
  best = '0;
  res  = '0;
  for (int i = 1; i < num_irq; i++) begin
    if (m_ip[i] && m_ie[i]) begin
      key = {1'b1, level_of(m_ctl[i], m_cfg.nlbits), prio_of(m_ctl[i], m_cfg.nlbits),
             5'(31 - i)};
      if (key > best) begin
        best = key;
        res  = {1'b1, 12'(i)};
      end
    end
  end
  return res;
endfunction

function automatic logic [31:0] expected_read(input logic [31:0] addr);
  int id;
  id = addr[6:2];
  if (addr[31:2] == cfg_addr[31:2]) return {25'd0, m_cfg};
  if (addr[31:2] == info_addr[31:2]) return {1'b0, 6'd0, 4'd8, 4'd0, 4'd0, 13'd32};
  if ((addr >= int_base) && (addr < int_end)) begin
    return {m_ctl[id], m_mode[id], 3'd0, m_trig[id], m_shv[id], 7'd0, m_ie[id], 7'd0,
            m_ip[id]};
  end
  return 32'h0;
endfunction

/* dv/clic_tb.sv */
module clic_tb
  import clic_params_pkg::*;
  import clic_map_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int watchdog_ns = 8 * 20 + 5 * 400 * 20;  // reset plus five tests of 400 cycles

  logic                    clock;
  logic                    reset;
  logic                    bus_valid;
  logic [31:0]             bus_addr;
  logic [31:0]             bus_wdata;
  logic [3:0]              bus_wstrb;
  logic [31:0]             bus_rdata;
  logic                    bus_ready;
  logic [num_irq-1:0]      irq_lines;
  logic                    meip;
  logic [irq_id_width-1:0] meid;

  // reference model of the register state
  cfg_t               m_cfg;
  logic [num_irq-1:0] m_ie;
  logic [num_irq-1:0] m_ip;
  logic [num_irq-1:0] m_shv;
  logic [num_irq-1:0] m_line;  // previous line sample
  logic [7:0]         m_ctl  [num_irq];
  trig_t              m_trig [num_irq];
  logic [1:0]         m_mode [num_irq];

  int_word_t   wr_word;
  logic [4:0]  wr_id;
  logic        wr_int;
  logic [12:0] exp_win_q1;
  logic [12:0] exp_win_q2;  // {meip, meid} two edges behind the model
  logic [31:0] exp_rdata_q;

  int          errors = 0;
  int          tests_run = 0;
  int          tests_bad = 0;
  int          errs_before;
  int          seed = 89082;
  logic [31:0] rnd;
  logic [3:0]  nl;

  `include "clic_bus_tasks.svh"

  clic_top dut_i (
    .clock     (clock),
    .reset     (reset),
    .bus_valid (bus_valid),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_wstrb (bus_wstrb),
    .bus_rdata (bus_rdata),
    .bus_ready (bus_ready),
    .irq_lines (irq_lines),
    .meip      (meip),
    .meid      (meid)
  );

  always #10 clock = ~clock;

  // ==============================
  // reference model
  // ==============================

  assign wr_word = bus_wdata;
  assign wr_id   = bus_addr[6:2];
  assign wr_int  = (bus_addr >= int_base) && (bus_addr < int_end);

  always @(posedge clock) begin
    if (reset) begin
      m_cfg  <= '0;
      m_ie   <= '0;
      m_ip   <= '0;
      m_shv  <= '0;
      m_line <= '0;
      for (int i = 0; i < num_irq; i++) begin
        m_ctl[i]  <= '0;
        m_trig[i] <= '0;
        m_mode[i] <= '0;
      end
    end else begin
      m_line <= irq_lines;
      for (int i = 0; i < num_irq; i++) begin
        if (!m_trig[i][0]) begin
          m_ip[i] <= irq_lines[i];
        end else if (m_trig[i][1] ? (m_line[i] && !irq_lines[i])
                                  : (!m_line[i] && irq_lines[i])) begin
          m_ip[i] <= 1'b1;  // edge beats software
        end else if (bus_valid && wr_int && bus_wstrb[0] && (wr_id == i)) begin
          m_ip[i] <= wr_word.ip;
        end
      end
      if (bus_valid && (bus_addr[31:2] == cfg_addr[31:2]) && bus_wstrb[0]) begin
        m_cfg <= bus_wdata[6:0];
      end
      if (bus_valid && wr_int) begin
        if (bus_wstrb[1]) m_ie[wr_id] <= wr_word.ie;
        if (bus_wstrb[2]) begin
          m_shv[wr_id]  <= wr_word.shv;
          m_trig[wr_id] <= wr_word.trig;
          m_mode[wr_id] <= wr_word.mode;
        end
        if (bus_wstrb[3]) m_ctl[wr_id] <= wr_word.ctl;
      end
    end
  end

  always @(posedge clock) begin
    exp_win_q1  <= model_winner();
    exp_win_q2  <= exp_win_q1;
    exp_rdata_q <= (bus_valid && bus_wstrb == 4'h0) ? expected_read(bus_addr) : 32'h0;
  end

  // ==============================
  // checks
  // ==============================

  ack_mapped: assert property (@(posedge clock) disable iff (reset)
      bus_valid && addr_mapped(bus_addr) |=> bus_ready)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: bus_ready expected 1 got %0b", $time, $sampled(bus_ready));
    end

  // idle cycles and unmapped requests alike
  no_spurious_ack: assert property (@(posedge clock) disable iff (reset)
      !(bus_valid && addr_mapped(bus_addr)) |=> !bus_ready)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: bus_ready expected 0 got %0b", $time, $sampled(bus_ready));
    end

  rdata_ok: assert property (@(posedge clock) disable iff (reset) bus_rdata == exp_rdata_q)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: bus_rdata expected %h got %h", $time,
               $sampled(exp_rdata_q), $sampled(bus_rdata));
    end

  meip_ok: assert property (@(posedge clock) disable iff (reset) meip == exp_win_q2[12])
    else begin
      errors++;
      $display("CHECK FAILED at %0t: meip expected %0b got %0b", $time,
               $sampled(exp_win_q2[12]), $sampled(meip));
    end

  meid_ok: assert property (@(posedge clock) disable iff (reset) meid == exp_win_q2[11:0])
    else begin
      errors++;
      $display("CHECK FAILED at %0t: meid expected %0d got %0d", $time,
               $sampled(exp_win_q2[11:0]), $sampled(meid));
    end

  // ==============================
  // tests
  // ==============================

  initial begin
    clock     = 1'b0;
    reset     = 1'b1;
    bus_valid = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_wstrb = '0;
    irq_lines = '0;
    idle(8);
    reset = 1'b0;

    errs_before = errors;
    bus_write(cfg_addr, 32'h0000_0035, 4'h1);
    bus_read(cfg_addr);
    bus_write(int_addr(5), 32'hffff_ffff, 4'h2);
    bus_read(int_addr(5));
    bus_write(int_addr(5), 32'hffff_ffff, 4'h8);
    bus_read(int_addr(5));
    bus_write(int_addr(5), 32'hffff_ffff, 4'h4);  // falling edge, shv and mode
    bus_read(int_addr(5));
    bus_write(int_addr(5), 32'hffff_ffff, 4'h1);
    bus_read(int_addr(5));
    bus_write(info_addr, 32'hffff_ffff, 4'hf);
    bus_read(info_addr);
    bus_read(cfg_addr);
    bus_read(int_addr(5));
    idle(4);
    clear_all();
    finish_test("register access", errs_before);

    errs_before = errors;
    bus_read(32'h0000_0008);
    bus_read(32'h0000_0800);
    bus_write(32'h0000_0ffc, 32'hffff_ffff, 4'hf);
    bus_read(int_end);
    bus_write(int_end + 32'd4, 32'hffff_ffff, 4'hf);
    bus_read(32'h8000_0000);
    bus_read(int_addr(num_irq - 1));
    idle(4);
    finish_test("unmapped addresses", errs_before);

    errs_before = errors;
    bus_write(int_addr(7), 32'h8000_0100, 4'hf);  // level, enabled
    irq_lines[7] = 1'b1;
    idle(5);
    bus_read(int_addr(7));
    irq_lines[7] = 1'b0;
    idle(5);
    bus_write(int_addr(7), 32'h0000_0001, 4'h1);
    idle(5);
    bus_read(int_addr(7));
    clear_all();
    finish_test("level trigger", errs_before);

    errs_before = errors;
    irq_lines[9] = 1'b1;
    idle(2);
    bus_write(int_addr(9), 32'h4002_0100, 4'hf);   // rising
    bus_write(int_addr(10), 32'h6006_0100, 4'hf);  // falling
    bus_write(int_addr(9), 32'h0, 4'h1);
    irq_lines[9] = 1'b0;
    idle(5);
    irq_lines[9] = 1'b1;
    idle(1);
    irq_lines[9] = 1'b0;
    idle(5);
    bus_read(int_addr(9));
    bus_write(int_addr(9), 32'h0, 4'h1);
    irq_lines[10] = 1'b1;
    idle(5);
    irq_lines[10] = 1'b0;
    idle(5);
    bus_write(int_addr(10), 32'h0, 4'h1);
    idle(5);
    bus_write(int_addr(10), 32'h1, 4'h1);
    idle(5);
    bus_read(int_addr(10));
    clear_all();
    finish_test("edge triggers", errs_before);

    errs_before = errors;
    for (int r = 0; r < 8; r++) begin
      nl = $unsigned($random(seed)) % 10;
      bus_write(cfg_addr, {27'd0, nl, 1'b0}, 4'h1);
      for (int id = 0; id < num_irq; id++) begin
        rnd = $random(seed);
        bus_write(int_addr(id), {rnd[7:0] & 8'he7, 15'd0, rnd[8], 8'h00}, 4'ha);
      end
      irq_lines = $random(seed) | 32'h1;  // id 0 always pending
      idle(6);
      irq_lines = $random(seed);
      idle(6);
    end
    idle(4);
    finish_test("arbitration", errs_before);

    $display("%0d tests run, %0d failing, %0d check errors", tests_run, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #watchdog_ns;
    $display("watchdog expired, the simulation hung before all tests completed");
    $display("tests failed");
    $finish;
  end

endmodule

/* design/clic_top.sv */
module clic_top
  import clic_params_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    bus_valid,
  input  logic [31:0]             bus_addr,
  input  logic [31:0]             bus_wdata,
  input  logic [3:0]              bus_wstrb,
  output logic [31:0]             bus_rdata,
  output logic                    bus_ready,
  input  logic [num_irq-1:0]      irq_lines,
  output logic                    meip,
  output logic [irq_id_width-1:0] meid
);

  clic_irq_if irq_i ();

  // ==============================
  // register file and bus
  // ==============================

  clic_regs regs_i (
    .clock     (clock),
    .reset     (reset),
    .bus_valid (bus_valid),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_wstrb (bus_wstrb),
    .bus_rdata (bus_rdata),
    .bus_ready (bus_ready),
    .irq       (irq_i.regs)
  );

  clic_gateway gateway_i (
    .clock     (clock),
    .reset     (reset),
    .irq_lines (irq_lines),  // sampled every cycle
    .irq       (irq_i.gateway)
  );

  clic_arbiter arbiter_i (
    .clock (clock),
    .reset (reset),
    .irq   (irq_i.arbiter),
    .meip  (meip),
    .meid  (meid)
  );

endmodule

/* design/clic_arbiter.sv */
module clic_arbiter
  import clic_params_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  clic_irq_if.arbiter             irq,
  output logic                    meip,
  output logic [irq_id_width-1:0] meid
);

  logic [ctl_bits-1:0]     lvl_mask;
  logic [ctl_bits-1:0]     level [num_irq];
  logic [ctl_bits-1:0]     prio  [num_irq];
  logic [num_irq-1:0]      cand;

  logic                    grp_valid [arb_groups];
  logic [irq_id_width-1:0] grp_id    [arb_groups];
  logic [ctl_bits-1:0]     grp_level [arb_groups];
  logic [ctl_bits-1:0]     grp_prio  [arb_groups];

  logic                    s1_valid [arb_groups];
  logic [irq_id_width-1:0] s1_id    [arb_groups];
  logic [ctl_bits-1:0]     s1_level [arb_groups];
  logic [ctl_bits-1:0]     s1_prio  [arb_groups];

  logic                    best_valid;
  logic [irq_id_width-1:0] best_id;
  logic [ctl_bits-1:0]     best_level;
  logic [ctl_bits-1:0]     best_prio;

  // strictly better only, so an equal candidate keeps the lower id
  function automatic logic beats(input logic a_valid, input logic [ctl_bits-1:0] a_level,
                                 input logic [ctl_bits-1:0] a_prio, input logic b_valid,
                                 input logic [ctl_bits-1:0] b_level,
                                 input logic [ctl_bits-1:0] b_prio);
    return a_valid && (!b_valid || (a_level > b_level) ||
                       ((a_level == b_level) && (a_prio > b_prio)));
  endfunction

  // ==============================
  // level and priority per id
  // ==============================

  // low (ctl_bits - nlbits) bits, empty once nlbits covers the whole byte
  assign lvl_mask = {ctl_bits{1'b1}} >> irq.nlbits;

  always_comb begin
    for (int i = 0; i < num_irq; i++) begin
      level[i] = irq.ctl[i] | lvl_mask;
      prio[i]  = irq.ctl[i] | ~lvl_mask;
      cand[i]  = irq.ip[i] && irq.ie[i] && (i != 0);  // id 0 never competes
    end
  end

  // ==============================
  // stage 1, one winner per group
  // ==============================

  always_comb begin
    int id;
    for (int g = 0; g < arb_groups; g++) begin
      grp_valid[g] = 1'b0;
      grp_id[g]    = '0;
      grp_level[g] = '0;
      grp_prio[g]  = '0;
      for (int k = 0; k < arb_group_size; k++) begin
        id = g * arb_group_size + k;
        if (beats(cand[id], level[id], prio[id], grp_valid[g], grp_level[g], grp_prio[g])) begin
          grp_valid[g] = 1'b1;
          grp_id[g]    = irq_id_width'(id);
          grp_level[g] = level[id];
          grp_prio[g]  = prio[id];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int g = 0; g < arb_groups; g++) begin
        s1_valid[g] <= 1'b0;
        s1_id[g]    <= '0;
        s1_level[g] <= '0;
        s1_prio[g]  <= '0;
      end
    end else begin
      s1_valid <= grp_valid;
      s1_id    <= grp_id;
      s1_level <= grp_level;
      s1_prio  <= grp_prio;
    end
  end

  // ==============================
  // stage 2, across groups
  // ==============================

  always_comb begin
    best_valid = 1'b0;
    best_id    = '0;
    best_level = '0;
    best_prio  = '0;
    for (int g = 0; g < arb_groups; g++) begin
      if (beats(s1_valid[g], s1_level[g], s1_prio[g], best_valid, best_level, best_prio)) begin
        best_valid = 1'b1;
        best_id    = s1_id[g];
        best_level = s1_level[g];
        best_prio  = s1_prio[g];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      meip <= 1'b0;
      meid <= '0;
    end else begin
      meip <= best_valid;
      meid <= best_id;  // zero when nothing is pending
    end
  end

endmodule

/* design/clic_gateway.sv */
module clic_gateway
  import clic_params_pkg::*;
  import clic_map_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  logic [num_irq-1:0] irq_lines,
  clic_irq_if.gateway        irq
);

  logic [num_irq-1:0] line_q;   // previous sample
  logic [num_irq-1:0] rise;
  logic [num_irq-1:0] fall;
  logic [num_irq-1:0] ip_next;

  assign rise = irq_lines & ~line_q;
  assign fall = ~irq_lines & line_q;

  // ==============================
  // next pending state
  // ==============================

  always_comb begin
    for (int i = 0; i < num_irq; i++) begin
      if (!irq.trig[i][trig_edge_bit]) begin
        ip_next[i] = irq_lines[i];  // level mode tracks the line
      end else begin
        ip_next[i] = irq.ip[i];
        if (irq.ip_wr && (irq.ip_wr_id == irq_idx_width'(i))) begin
          ip_next[i] = irq.ip_wr_value;
        end
        // hardware edge beats a software clear in the same cycle
        if (irq.trig[i][trig_fall_bit] ? fall[i] : rise[i]) begin
          ip_next[i] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      line_q <= '0;
      irq.ip <= '0;
    end else begin
      line_q <= irq_lines;
      irq.ip <= ip_next;
    end
  end

endmodule

/* design/clic_regs.sv */
module clic_regs
  import clic_params_pkg::*;
  import clic_map_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        bus_valid,
  input  logic [31:0] bus_addr,
  input  logic [31:0] bus_wdata,
  input  logic [3:0]  bus_wstrb,
  output logic [31:0] bus_rdata,
  output logic        bus_ready,
  clic_irq_if.regs    irq
);

  reg_word_u                wr_view;
  reg_word_u                rd_view;
  cfg_t                     cfg_q;
  logic                     shv_q  [num_irq];
  logic [1:0]               mode_q [num_irq];
  logic [irq_idx_width-1:0] idx;
  logic                     is_cfg;
  logic                     is_info;
  logic                     is_int;
  logic                     mapped;
  logic                     is_write;
  logic [31:0]              rdata_q;
  logic                     ready_q;

  // ==============================
  // decode
  // ==============================

  assign wr_view  = bus_wdata;
  assign idx      = bus_addr[irq_idx_width+1:2];  // word index inside the int region
  assign is_cfg   = (bus_addr[31:2] == cfg_addr[31:2]);
  assign is_info  = (bus_addr[31:2] == info_addr[31:2]);
  assign is_int   = (bus_addr >= int_base) && (bus_addr < int_end);
  assign mapped   = is_cfg || is_info || is_int;
  assign is_write = |bus_wstrb;

  assign irq.nlbits = cfg_q.nlbits;

  // pending lane goes to the gateway, which checks the trigger mode
  assign irq.ip_wr       = bus_valid && is_int && is_write && bus_wstrb[0];
  assign irq.ip_wr_id    = idx;
  assign irq.ip_wr_value = wr_view.intw.ip;

  // ==============================
  // register writes
  // ==============================

  always_ff @(posedge clock) begin
    if (reset) begin
      cfg_q  <= '0;
      irq.ie <= '0;
      for (int i = 0; i < num_irq; i++) begin
        irq.ctl[i]  <= '0;
        irq.trig[i] <= '0;
        shv_q[i]    <= 1'b0;
        mode_q[i]   <= '0;
      end
    end else if (bus_valid && is_write) begin
      if (is_cfg && bus_wstrb[0]) begin
        cfg_q <= wr_view.cfg.fields;  // all cfg fields sit in lane 0
      end
      if (is_int) begin
        if (bus_wstrb[1]) begin
          irq.ie[idx] <= wr_view.intw.ie;
        end
        if (bus_wstrb[2]) begin
          shv_q[idx]    <= wr_view.intw.shv;
          irq.trig[idx] <= wr_view.intw.trig;
          mode_q[idx]   <= wr_view.intw.mode;
        end
        if (bus_wstrb[3]) begin
          irq.ctl[idx] <= wr_view.intw.ctl[ctl_bits-1:0];
        end
      end
    end
  end

  // ==============================
  // read data and acknowledge
  // ==============================

  always_comb begin
    rd_view = '0;
    if (is_cfg) begin
      rd_view.cfg.fields = cfg_q;
    end else if (is_info) begin
      rd_view.info = info_value;
    end else if (is_int) begin
      rd_view.intw.ip   = irq.ip[idx];
      rd_view.intw.ie   = irq.ie[idx];
      rd_view.intw.shv  = shv_q[idx];
      rd_view.intw.trig = irq.trig[idx];
      rd_view.intw.mode = mode_q[idx];
      rd_view.intw.ctl  = irq.ctl[idx];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= 1'b0;
      rdata_q <= '0;
    end else begin
      ready_q <= bus_valid && mapped;  // unmapped requests are dropped
      rdata_q <= '0;
      if (bus_valid && mapped && !is_write) begin
        rdata_q <= rd_view;
      end
    end
  end

  assign bus_ready = ready_q;
  assign bus_rdata = rdata_q;

endmodule

/* design/clic_irq_if.sv */
interface clic_irq_if
  import clic_params_pkg::*;
  import clic_map_pkg::*;
();

  logic [num_irq-1:0]       ip;              // pending, owned by the gateway
  logic [num_irq-1:0]       ie;              // enables
  logic [ctl_bits-1:0]      ctl [num_irq];   // level/priority byte
  trig_t                    trig [num_irq];  // trigger attribute
  logic [3:0]               nlbits;          // level bits from cfg

  // software pending write, one cycle strobe
  logic                     ip_wr;
  logic [irq_idx_width-1:0] ip_wr_id;
  logic                     ip_wr_value;

  modport regs (
    output ie, ctl, trig, nlbits,
    output ip_wr, ip_wr_id, ip_wr_value,
    input  ip
  );

  modport gateway (
    input  trig,
    input  ip_wr, ip_wr_id, ip_wr_value,
    output ip
  );

  modport arbiter (
    input ip, ie, ctl, nlbits
  );

endinterface

/* design/clic_map_pkg.sv */
package clic_map_pkg;
  import clic_params_pkg::*;

  // ==============================
  // address map
  // ==============================

  localparam logic [31:0] cfg_addr  = 32'd0;
  localparam logic [31:0] info_addr = 32'd4;
  localparam logic [31:0] int_base  = 32'd4096;
  localparam logic [31:0] int_end   = int_base + 32'(4 * num_irq);  // one word per id

  // trigger attribute, bit 0 edge mode, bit 1 falling polarity
  typedef logic [1:0] trig_t;

  localparam int trig_edge_bit = 0;
  localparam int trig_fall_bit = 1;

  // ==============================
  // register layouts
  // ==============================

  typedef struct packed {
    logic [1:0] nmbits;
    logic [3:0] nlbits;
    logic       nvbits;
  } cfg_t;

  typedef struct packed {
    logic [24:0] rsvd;
    cfg_t        fields;  // bits 6:0
  } cfg_word_t;

  typedef struct packed {
    logic        rsvd;
    logic [5:0]  num_trigger;    // 30:25
    logic [3:0]  num_intctlbit;  // 24:21
    logic [3:0]  arch_version;   // 20:17
    logic [3:0]  impl_version;   // 16:13
    logic [12:0] num_interrupt;  // 12:0
  } info_t;

  typedef struct packed {
    logic [7:0] ctl;    // byte 3
    logic [1:0] mode;
    logic [2:0] rsvd2;
    trig_t      trig;
    logic       shv;    // byte 2
    logic [6:0] rsvd1;
    logic       ie;     // byte 1
    logic [6:0] rsvd0;
    logic       ip;     // byte 0
  } int_word_t;

  // the same bus word seen through the region it addresses
  typedef union packed {
    cfg_word_t cfg;
    info_t     info;
    int_word_t intw;
  } reg_word_u;

  // fixed info contents, no trigger table
  localparam info_t info_value = '{1'b0, 6'd0, 4'(ctl_bits), arch_version, impl_version,
                                   13'(num_irq)};

endpackage

/* design/clic_params_pkg.sv */
package clic_params_pkg;

  // ==============================
  // controller sizes
  // ==============================

  localparam int num_irq       = 32;  // interrupt lines
  localparam int irq_id_width  = 12;  // width of meid
  localparam int irq_idx_width = 5;   // selects one of num_irq
  localparam int ctl_bits      = 8;   // implemented clicintctl bits

  // ==============================
  // version fields of the info register
  // ==============================

  localparam logic [3:0] arch_version = 4'd0;
  localparam logic [3:0] impl_version = 4'd0;

  // ==============================
  // arbiter shape
  // ==============================

  localparam int arb_group_size = 8;                         // inputs per stage 1 group
  localparam int arb_groups     = num_irq / arb_group_size;  // stage 2 inputs

endpackage
